//--- Makefile
# Verilator build and run for the fetch front end

TOP = fetch_tb

.PHONY: all compile run clean

all: run

# build the simulation binary from the file list
compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) \
		-f compile.f -Mdir obj_dir -o V$(TOP)

# run and decide pass or fail from the log
run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- compile.f
logic/rv_isa_pkg.sv
logic/fetch_pkg.sv
logic/fetch_unit.sv
logic/inst_align.sv
logic/c_expand.sv
logic/fetch_top.sv
test/fetch_tb.sv

//--- logic/c_expand.sv
////////////////////////////////////////////////////////////////////////////
// compressed instruction expander
// one register stage that rewrites c.addi, c.li, c.mv, c.add and c.j
// into base encodings, passes full instructions through and flags
// every other compressed halfword as illegal
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module c_expand (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         stall_i,
    input  logic                         redirect_i,
    input  logic                         al_valid_i,
    input  logic [fetch_pkg::ADDR_W-1:0] al_pc_i,
    input  rv_isa_pkg::instr_word_u      al_word_i,
    input  logic                         al_compressed_i,
    input  logic [fetch_pkg::TAG_W-1:0]  al_tag_i,
    output logic                         inst_valid_o,
    output logic [fetch_pkg::ADDR_W-1:0] inst_pc_o,
    output logic [31:0]                  inst_o,
    output logic                         compressed_o,
    output logic                         illegal_o,
    output logic [fetch_pkg::TAG_W-1:0]  tag_o
);

    import rv_isa_pkg::*;

    logic [15:0] c_half;
    logic [4:0]  c_rd;
    logic [4:0]  c_rs2;
    logic [11:0] ci_imm;
    logic [20:0] cj_off;
    logic [31:0] exp_word;
    logic        exp_illegal;
    logic        inst_valid_q;

    assign c_half = al_word_i.half.lo;
    assign c_rd   = c_half[11:7];
    assign c_rs2  = c_half[6:2];

    // ci immediate, sign from bit 12
    assign ci_imm = {{6{c_half[12]}}, c_half[12], c_half[6:2]};

    // cj offset unscrambled, bit 0 always zero
    assign cj_off = {{10{c_half[12]}}, c_half[8], c_half[10:9], c_half[6], c_half[7],
                     c_half[2], c_half[11], c_half[5:3], 1'b0};

    always_comb begin
        exp_word    = '0;
        exp_illegal = 1'b0;
        if (!al_compressed_i) begin
            exp_word = al_word_i.full;
        end else begin
            case ({c_half[1:0], c_half[15:13]})
                {CQ1, C_F3_ADDI}: exp_word = {ci_imm, c_rd, F3_ADDI, c_rd, OPC_OP_IMM};
                {CQ1, C_F3_LI}:   exp_word = {ci_imm, REG_X0, F3_ADDI, c_rd, OPC_OP_IMM};
                {CQ1, C_F3_J}: begin
                    exp_word = {cj_off[20], cj_off[10:1], cj_off[11], cj_off[19:12],
                                REG_X0, OPC_JAL};
                end
                {CQ2, C_F3_MV_ADD}: begin
                    // rs2 of x0 means c.jr, c.jalr or c.ebreak
                    if (c_rs2 == REG_X0) begin
                        exp_illegal = 1'b1;
                    end else if (c_half[12]) begin
                        exp_word = {F7_ADD, c_rs2, c_rd, F3_ADD, c_rd, OPC_OP};
                    end else begin
                        exp_word = {F7_ADD, c_rs2, REG_X0, F3_ADD, c_rd, OPC_OP};
                    end
                end
                default: exp_illegal = 1'b1;
            endcase
        end
    end

    // held result shows once, on the first cycle out of stall
    assign inst_valid_o = inst_valid_q & ~stall_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            inst_valid_q <= 1'b0;
        end else if (redirect_i) begin
            inst_valid_q <= 1'b0;
        end else if (!stall_i) begin
            inst_valid_q <= al_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i && al_valid_i) begin
            inst_pc_o    <= al_pc_i;
            inst_o       <= exp_word;
            compressed_o <= al_compressed_i;
            illegal_o    <= exp_illegal;
            tag_o        <= al_tag_i;
        end
    end

endmodule

//--- logic/fetch_pkg.sv
////////////////////////////////////////////////////////////////////////////
// fetch front end constants
// address and tag widths, the default boot address and the pc steps
// used for word and halfword sequencing
////////////////////////////////////////////////////////////////////////////

package fetch_pkg;

    // byte address width of pc and memory
    localparam int ADDR_W = 32;

    // redirect epoch counter width
    localparam int TAG_W = 3;

    // default first fetch address, top level may override
    localparam logic [ADDR_W-1:0] RESET_PC = 32'h0000_0000;

    ////////////////////////////////////////////////////////////////////////////
    // pc steps
    ////////////////////////////////////////////////////////////////////////////

    // one compressed instruction
    localparam logic [ADDR_W-1:0] HALF_STEP = 2;

    // one memory word or one full instruction
    localparam logic [ADDR_W-1:0] WORD_STEP = 4;

    // clears the halfword select and byte bits of a pc
    localparam logic [ADDR_W-1:0] WORD_MASK = {{(ADDR_W-2){1'b1}}, 2'b00};

endpackage

//--- logic/fetch_top.sv
////////////////////////////////////////////////////////////////////////////
// rv32ic fetch front end
// fetch, align and expand in a chain, boot address passed down
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module fetch_top #(
    parameter logic [fetch_pkg::ADDR_W-1:0] BOOT_ADDR = fetch_pkg::RESET_PC
) (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         stall_i,
    input  logic                         redirect_i,
    input  logic [fetch_pkg::ADDR_W-1:0] redirect_pc_i,
    output logic                         mem_req_o,
    output logic [fetch_pkg::ADDR_W-1:0] mem_addr_o,
    input  logic [31:0]                  mem_rdata_i,
    output logic                         inst_valid_o,
    output logic [fetch_pkg::ADDR_W-1:0] inst_pc_o,
    output logic [31:0]                  inst_o,
    output logic                         compressed_o,
    output logic                         illegal_o,
    output logic [fetch_pkg::TAG_W-1:0]  tag_o
);

    import fetch_pkg::*;
    import rv_isa_pkg::*;

    // fetch to aligner
    logic              word_valid;
    logic              word_first;
    logic [ADDR_W-1:0] word_pc;
    logic [31:0]       word_data;
    logic [TAG_W-1:0]  word_tag;
    logic              align_hold;

    // aligner to expander
    logic              al_valid;
    logic [ADDR_W-1:0] al_pc;
    instr_word_u       al_word;
    logic              al_compressed;
    logic [TAG_W-1:0]  al_tag;

    fetch_unit #(
        .BOOT_ADDR(BOOT_ADDR)
    ) fetch_unit_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .stall_i      (stall_i),
        .redirect_i   (redirect_i),
        .redirect_pc_i(redirect_pc_i),
        .align_hold_i (align_hold),
        .mem_rdata_i  (mem_rdata_i),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .word_valid_o (word_valid),
        .word_first_o (word_first),
        .word_pc_o    (word_pc),
        .word_data_o  (word_data),
        .word_tag_o   (word_tag)
    );

    inst_align inst_align_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .stall_i        (stall_i),
        .redirect_i     (redirect_i),
        .word_valid_i   (word_valid),
        .word_first_i   (word_first),
        .word_pc_i      (word_pc),
        .word_data_i    (word_data),
        .word_tag_i     (word_tag),
        .align_hold_o   (align_hold),
        .al_valid_o     (al_valid),
        .al_pc_o        (al_pc),
        .al_word_o      (al_word),
        .al_compressed_o(al_compressed),
        .al_tag_o       (al_tag)
    );

    c_expand c_expand_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .stall_i        (stall_i),
        .redirect_i     (redirect_i),
        .al_valid_i     (al_valid),
        .al_pc_i        (al_pc),
        .al_word_i      (al_word),
        .al_compressed_i(al_compressed),
        .al_tag_i       (al_tag),
        .inst_valid_o   (inst_valid_o),
        .inst_pc_o      (inst_pc_o),
        .inst_o         (inst_o),
        .compressed_o   (compressed_o),
        .illegal_o      (illegal_o),
        .tag_o          (tag_o)
    );

endmodule

//--- logic/fetch_unit.sv
////////////////////////////////////////////////////////////////////////////
// word fetch sequencer
// issues one word read per cycle to a one-cycle synchronous memory,
// pairs each response with its pc, drops reads older than a redirect
// and parks a response that lands while the front end is held
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module fetch_unit #(
    parameter logic [fetch_pkg::ADDR_W-1:0] BOOT_ADDR = fetch_pkg::RESET_PC
) (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         stall_i,
    input  logic                         redirect_i,
    input  logic [fetch_pkg::ADDR_W-1:0] redirect_pc_i,
    input  logic                         align_hold_i,
    input  logic [31:0]                  mem_rdata_i,
    output logic                         mem_req_o,
    output logic [fetch_pkg::ADDR_W-1:0] mem_addr_o,
    output logic                         word_valid_o,
    output logic                         word_first_o,
    output logic [fetch_pkg::ADDR_W-1:0] word_pc_o,
    output logic [31:0]                  word_data_o,
    output logic [fetch_pkg::TAG_W-1:0]  word_tag_o
);

    import fetch_pkg::*;

    logic              started_q;
    logic [ADDR_W-1:0] pc_q;
    logic              first_q;
    logic [TAG_W-1:0]  tag_q;
    logic              out_valid_q;
    logic [ADDR_W-1:0] out_pc_q;
    logic              out_first_q;
    logic              skid_valid_q;
    logic [31:0]       skid_data_q;
    logic              held;

    // stall or an unissued compressed halfword in the aligner
    assign held = stall_i | align_hold_i;

    // no read in a held or redirect cycle
    assign mem_req_o  = started_q & ~held & ~redirect_i;
    assign mem_addr_o = pc_q & WORD_MASK;

    // skid word goes first, it is older than any new read
    assign word_valid_o = (out_valid_q | skid_valid_q) & ~held & ~redirect_i;
    assign word_data_o  = skid_valid_q ? skid_data_q : mem_rdata_i;
    assign word_pc_o    = out_pc_q;
    assign word_first_o = out_first_q;
    // older epochs never get through, so the live tag is the word's tag
    assign word_tag_o   = tag_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            started_q    <= 1'b0;
            pc_q         <= BOOT_ADDR;
            first_q      <= 1'b1;
            tag_q        <= '0;
            out_valid_q  <= 1'b0;
            skid_valid_q <= 1'b0;
        end else begin
            started_q <= 1'b1;
            if (redirect_i) begin
                // new epoch, reads in flight are dropped
                pc_q         <= redirect_pc_i;
                first_q      <= 1'b1;
                tag_q        <= tag_q + 1'b1;
                out_valid_q  <= 1'b0;
                skid_valid_q <= 1'b0;
            end else begin
                out_valid_q  <= mem_req_o;
                // a held word stays parked, otherwise it was consumed
                skid_valid_q <= held & (skid_valid_q | out_valid_q);
                if (mem_req_o) begin
                    pc_q    <= (pc_q & WORD_MASK) + WORD_STEP;
                    first_q <= 1'b0;
                end
            end
        end
    end

    // pc of the outstanding read and the parked response word
    always_ff @(posedge clk) begin
        if (mem_req_o) begin
            out_pc_q    <= pc_q;
            out_first_q <= first_q;
        end
        if (out_valid_q && held) begin
            skid_data_q <= mem_rdata_i;
        end
    end

endmodule

//--- logic/inst_align.sv
////////////////////////////////////////////////////////////////////////////
// instruction aligner
// cuts halfword-granular instructions out of the word stream and
// registers at most one per cycle, joining full instructions that
// straddle two words and draining a second compressed halfword alone
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module inst_align (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         stall_i,
    input  logic                         redirect_i,
    input  logic                         word_valid_i,
    input  logic                         word_first_i,
    input  logic [fetch_pkg::ADDR_W-1:0] word_pc_i,
    input  logic [31:0]                  word_data_i,
    input  logic [fetch_pkg::TAG_W-1:0]  word_tag_i,
    output logic                         align_hold_o,
    output logic                         al_valid_o,
    output logic [fetch_pkg::ADDR_W-1:0] al_pc_o,
    output rv_isa_pkg::instr_word_u      al_word_o,
    output logic                         al_compressed_o,
    output logic [fetch_pkg::TAG_W-1:0]  al_tag_o
);

    import fetch_pkg::*;
    import rv_isa_pkg::*;

    logic              pend_valid_q;
    logic [15:0]       pend_half_q;
    logic [ADDR_W-1:0] next_pc_q;
    instr_word_u       in_word;
    logic [ADDR_W-1:0] cur_pc;
    logic              issue;
    logic [ADDR_W-1:0] iss_pc;
    instr_word_u       iss_word;
    logic              iss_comp;
    logic              pend_nxt_v;
    logic [15:0]       pend_nxt_h;
    logic [ADDR_W-1:0] pc_nxt;

    assign in_word = word_data_i;

    // first word after a redirect carries the exact target pc
    assign cur_pc = word_first_i ? word_pc_i : next_pc_q;

    // a complete compressed halfword is waiting, next word must not come
    assign align_hold_o = pend_valid_q & is_compressed(pend_half_q);

    ////////////////////////////////////////////////////////////////////////////
    // next instruction select
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        issue      = 1'b0;
        iss_pc     = cur_pc;
        iss_word   = '0;
        iss_comp   = 1'b0;
        pend_nxt_v = pend_valid_q;
        pend_nxt_h = pend_half_q;
        pc_nxt     = next_pc_q;
        if (align_hold_o) begin
            // leftover compressed upper half, no word arrives this cycle
            issue             = 1'b1;
            iss_pc            = next_pc_q;
            iss_word.half.lo  = pend_half_q;
            iss_comp          = 1'b1;
            pend_nxt_v        = 1'b0;
            pc_nxt            = next_pc_q + HALF_STEP;
        end else if (word_valid_i) begin
            if (pend_valid_q) begin
                // straddling full instruction
                issue            = 1'b1;
                iss_pc           = next_pc_q;
                iss_word.half.hi = in_word.half.lo;
                iss_word.half.lo = pend_half_q;
                pend_nxt_h       = in_word.half.hi;
                pc_nxt           = next_pc_q + WORD_STEP;
            end else if (word_first_i && word_pc_i[1]) begin
                // target in upper half, lower half skipped
                if (is_compressed(in_word.half.hi)) begin
                    issue            = 1'b1;
                    iss_word.half.lo = in_word.half.hi;
                    iss_comp         = 1'b1;
                    pc_nxt           = cur_pc + HALF_STEP;
                end else begin
                    // full instruction, wait for its upper half
                    pend_nxt_v = 1'b1;
                    pend_nxt_h = in_word.half.hi;
                    pc_nxt     = cur_pc;
                end
            end else if (is_compressed(in_word.half.lo)) begin
                // upper half kept for the next cycle
                issue            = 1'b1;
                iss_word.half.lo = in_word.half.lo;
                iss_comp         = 1'b1;
                pend_nxt_v       = 1'b1;
                pend_nxt_h       = in_word.half.hi;
                pc_nxt           = cur_pc + HALF_STEP;
            end else begin
                // aligned full instruction
                issue    = 1'b1;
                iss_word = in_word;
                pc_nxt   = cur_pc + WORD_STEP;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // state and output register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pend_valid_q <= 1'b0;
            next_pc_q    <= '0;
            al_valid_o   <= 1'b0;
        end else if (redirect_i) begin
            pend_valid_q <= 1'b0;
            al_valid_o   <= 1'b0;
        end else if (!stall_i) begin
            pend_valid_q <= pend_nxt_v;
            next_pc_q    <= pc_nxt;
            al_valid_o   <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            pend_half_q <= pend_nxt_h;
            if (issue) begin
                al_pc_o         <= iss_pc;
                al_word_o       <= iss_word;
                al_compressed_o <= iss_comp;
                al_tag_o        <= word_tag_i;
            end
        end
    end

endmodule

//--- logic/rv_isa_pkg.sv
////////////////////////////////////////////////////////////////////////////
// rv32ic instruction encodings
// word view shared by the aligner and the expander, the base opcodes
// and funct fields of the expanded forms, and the compressed quadrant
// and funct3 values that select the supported c forms
////////////////////////////////////////////////////////////////////////////

package rv_isa_pkg;

    // one fetched word, seen whole or as two halfwords
    typedef union packed {
        logic [31:0] full;
        struct packed {
            logic [15:0] hi;
            logic [15:0] lo;
        } half;
    } instr_word_u;

    // base opcodes built by the expander
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // funct fields of addi and add
    localparam logic [2:0] F3_ADDI = 3'b000;
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [6:0] F7_ADD  = 7'b0000000;
    localparam logic [4:0] REG_X0  = 5'd0;

    // compressed quadrants and funct3 codes
    localparam logic [1:0] CQ1         = 2'b01;
    localparam logic [1:0] CQ2         = 2'b10;
    localparam logic [2:0] C_F3_ADDI   = 3'b000;
    localparam logic [2:0] C_F3_LI     = 3'b010;
    localparam logic [2:0] C_F3_J      = 3'b101;
    localparam logic [2:0] C_F3_MV_ADD = 3'b100;

    // 32-bit encodings end in 2'b11, anything else is a c instruction
    function automatic logic is_compressed(input logic [15:0] half);
        return half[1:0] != 2'b11;
    endfunction

endpackage

//--- test/fetch_tb.sv
////////////////////////////////////////////////////////////////////////////
// fetch front end testbench
// one-cycle instruction memory, a mixed rv32ic program, random stall
// pulses and a redirect, output stream compared against a table
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module fetch_tb;

    import fetch_pkg::*;
    import rv_isa_pkg::*;

    localparam logic [ADDR_W-1:0] BOOT_ADDR = 32'h0000_0022;
    localparam logic [ADDR_W-1:0] JUMP_ADDR = 32'h0000_009A;
    localparam int                WAIT_MAX  = 100;
    // entries before the redirect
    localparam int                N_A       = 11;

    typedef struct packed {
        logic [31:0]      pc;
        logic [31:0]      inst;
        logic             comp;
        logic             ill;
        logic [TAG_W-1:0] tag;
    } exp_t;

    logic              clk;
    logic              reset_n;
    logic              stall;
    logic              redirect;
    logic [ADDR_W-1:0] redirect_pc;
    logic              mem_req;
    logic [ADDR_W-1:0] mem_addr;
    logic [31:0]       mem_rdata;
    logic              inst_valid;
    logic [ADDR_W-1:0] inst_pc;
    logic [31:0]       inst;
    logic              compressed;
    logic              illegal;
    logic [TAG_W-1:0]  tag;

    logic [31:0]       mem [64];
    logic              req_seen;
    logic [ADDR_W-1:0] addr_seen;
    logic              stall_en;
    logic              redirect_req;
    integer            seed;
    exp_t              exp_q [$];

    // halfwords from BOOT_ADDR: c.li, c.addi, c.mv, addi, c.add, add (straddle),
    // andi (straddle), c.j, c.jr, c.lw, addi
    logic [15:0] prog_a [15] = '{
        16'h428D, 16'h12FD, 16'h8316, 16'h0393, 16'h1230, 16'h931E, 16'h0433, 16'h0073,
        16'h7393, 16'h0FF3, 16'hA021, 16'h8082, 16'h4398, 16'h0093, 16'hFFF0
    };
    // from JUMP_ADDR: addi (straddle), c.li, c.j back, add (straddle), c.addi
    logic [15:0] prog_b [7] = '{
        16'h0493, 16'h0050, 16'h5579, 16'hBFF5, 16'h85B3, 16'h00A4, 16'h0591
    };

    fetch_top #(
        .BOOT_ADDR(BOOT_ADDR)
    ) dut_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .stall_i      (stall),
        .redirect_i   (redirect),
        .redirect_pc_i(redirect_pc),
        .mem_req_o    (mem_req),
        .mem_addr_o   (mem_addr),
        .mem_rdata_i  (mem_rdata),
        .inst_valid_o (inst_valid),
        .inst_pc_o    (inst_pc),
        .inst_o       (inst),
        .compressed_o (compressed),
        .illegal_o    (illegal),
        .tag_o        (tag)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // memory model and control drivers
    ////////////////////////////////////////////////////////////////////////////

    // request seen mid cycle, answered just after the next edge
    always @(negedge clk) begin
        req_seen  = mem_req;
        addr_seen = mem_addr;
    end

    always @(posedge clk) begin
        #2;
        if (req_seen) begin
            mem_rdata = mem[addr_seen[7:2]];
        end
    end

    // redirect goes out together with a one-cycle stall
    always @(posedge clk) begin
        #2;
        if (redirect_req) begin
            redirect     = 1'b1;
            redirect_pc  = JUMP_ADDR;
            stall        = 1'b1;
            redirect_req = 1'b0;
        end else begin
            redirect = 1'b0;
            stall    = stall_en && (($random(seed) & 7) == 0);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] want);
        if (got !== want) begin
            fail_stop($sformatf("ERR %0t %s got %h expected %h", $time, name, got, want));
        end
    endtask

    task automatic place_half(input logic [ADDR_W-1:0] addr, input logic [15:0] half);
        if (addr[1]) begin
            mem[addr[7:2]][31:16] = half;
        end else begin
            mem[addr[7:2]][15:0] = half;
        end
    endtask

    task automatic add_exp(input logic [31:0] pc, input logic [31:0] word,
                           input logic comp, input logic ill, input logic [TAG_W-1:0] t);
        exp_q.push_back('{pc, word, comp, ill, t});
    endtask

    task automatic wait_strobe(input int idx);
        int n;
        n = 0;
        @(negedge clk);
        while (!inst_valid && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (!inst_valid) begin
            fail_stop($sformatf("no instruction strobe for entry %0d", idx));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int i;
        int n;
        clk          = 1'b0;
        reset_n      = 1'b0;
        stall        = 1'b0;
        redirect     = 1'b0;
        redirect_pc  = '0;
        mem_rdata    = '0;
        stall_en     = 1'b0;
        redirect_req = 1'b0;
        seed         = 94488;

        // fill pattern varies with the whole word index
        for (i = 0; i < 64; i++) begin
            mem[i] = 32'h5A5A_0003 ^ (i << 8) ^ (i << 20);
        end
        for (i = 0; i < $size(prog_a); i++) begin
            place_half(BOOT_ADDR + 2 * i, prog_a[i]);
        end
        for (i = 0; i < $size(prog_b); i++) begin
            place_half(JUMP_ADDR + 2 * i, prog_b[i]);
        end

        // epoch 0, program from BOOT_ADDR
        add_exp(BOOT_ADDR, {12'd3, REG_X0, F3_ADDI, 5'd5, OPC_OP_IMM}, 1'b1, 1'b0, 3'd0);
        add_exp(32'h24, {12'hFFF, 5'd5, F3_ADDI, 5'd5, OPC_OP_IMM}, 1'b1, 1'b0, 3'd0);
        add_exp(32'h26, {F7_ADD, 5'd5, REG_X0, F3_ADD, 5'd6, OPC_OP}, 1'b1, 1'b0, 3'd0);
        add_exp(32'h28, 32'h1230_0393, 1'b0, 1'b0, 3'd0);
        add_exp(32'h2C, {F7_ADD, 5'd7, 5'd6, F3_ADD, 5'd6, OPC_OP}, 1'b1, 1'b0, 3'd0);
        add_exp(32'h2E, 32'h0073_0433, 1'b0, 1'b0, 3'd0);
        add_exp(32'h32, 32'h0FF3_7393, 1'b0, 1'b0, 3'd0);
        add_exp(32'h36, {1'b0, 10'd4, 1'b0, 8'd0, REG_X0, OPC_JAL}, 1'b1, 1'b0, 3'd0);
        // c.jr and c.lw are outside the supported set
        add_exp(32'h38, 32'h0, 1'b1, 1'b1, 3'd0);
        add_exp(32'h3A, 32'h0, 1'b1, 1'b1, 3'd0);
        add_exp(32'h3C, 32'hFFF0_0093, 1'b0, 1'b0, 3'd0);
        // epoch 1 after the redirect
        add_exp(JUMP_ADDR, 32'h0050_0493, 1'b0, 1'b0, 3'd1);
        add_exp(32'h9E, {12'hFFE, REG_X0, F3_ADDI, 5'd10, OPC_OP_IMM}, 1'b1, 1'b0, 3'd1);
        add_exp(32'hA0, {1'b1, 10'h3FE, 1'b1, 8'hFF, REG_X0, OPC_JAL}, 1'b1, 1'b0, 3'd1);
        add_exp(32'hA2, 32'h00A4_85B3, 1'b0, 1'b0, 3'd1);
        add_exp(32'hA6, {12'd4, 5'd11, F3_ADDI, 5'd11, OPC_OP_IMM}, 1'b1, 1'b0, 3'd1);

        // quiet outputs during reset
        repeat (15) @(posedge clk);
        @(negedge clk);
        check_val("inst_valid_o", inst_valid, 0);
        check_val("mem_req_o", mem_req, 0);
        @(posedge clk);
        #2;
        reset_n = 1'b1;
        @(negedge clk);
        check_val("mem_req_o", mem_req, 0);

        // first read must target the boot word
        n = 0;
        while (!mem_req && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (!mem_req) begin
            fail_stop("no memory request after reset");
        end
        check_val("mem_addr_o", mem_addr, {BOOT_ADDR[31:2], 2'b00});
        stall_en = 1'b1;

        for (i = 0; i < exp_q.size(); i++) begin
            wait_strobe(i);
            check_val("inst_pc_o", inst_pc, exp_q[i].pc);
            check_val("inst_o", inst, exp_q[i].inst);
            check_val("compressed_o", compressed, exp_q[i].comp);
            check_val("illegal_o", illegal, exp_q[i].ill);
            check_val("tag_o", tag, exp_q[i].tag);
            if (i == N_A - 1) begin
                redirect_req = 1'b1;
            end
        end

        $display("sim passed");
        $finish;
    end

endmodule
